/* Bender.yml */
package:
  name: opb_io

sources:
  - rtl/opb_io_pkg.sv
  - rtl/opb_reg_if.sv
  - rtl/opb_addr_decode.sv
  - rtl/output_reg_bank.sv
  - rtl/input_sampler.sv
  - rtl/read_data_mux.sv
  - rtl/opb_io_top.sv
  - target: test
    files:
      - dv/tb_opb_io_top.sv

/* dv/opb_io_golden.txt */
# Columns (hex): W addr data | R addr expected | I din_word switches | Z cycles expected_do
#                P dout lpmux adsel | C res_clk expected_pwm
# Reset values
R 000 F5F5F5F5
R 004 ACACACAC
R 008 00030001
R 00C 00000000
R 010 00000000
R 014 00000000
R 018 00000000
R 01C 00000000
P 0030001 0 00
C 1 000AAAAA
# Writable registers, masked to width
W 000 12345678
R 000 12345678
W 004 DEADBEEF
R 004 DEADBEEF
W 008 FFFFFFFF
P FFFFFFF 0 00
R 008 0FFFFFFF
W 00C FFFFFFF3
R 00C 00000003
P FFFFFFF 3 00
W 00C 0000000D
W 010 FFFFFF95
R 010 00000015
W 008 FA5A5C3C
R 008 0A5A5C3C
P A5A5C3C D 15
R 00C 0000000D
# Resolver outputs
W 014 FFF5A5A5
R 014 0005A5A5
C 0 000AAAAA
C 1 000F0F0F
W 014 000FFFFF
C 1 00055555
C 0 000AAAAA
# Input pins and switches
I 9A5C3D6E 0ABC
R 018 8A5C3D6E
R 01C 00000ABC
I 06002A00 000
R 018 06002A00
R 01C 00000000
I FFFFFFFF FFF
R 018 EFFFFF7F
R 01C 00000FFF
# Read only and unmapped
W 018 00000000
W 01C 00000000
R 018 EFFFFF7F
R 01C 00000FFF
R 020 00000000
R 0FC 00000000
R 100000 00000000
R 006 DEADBEEF
Z 10 00000000
R 000 12345678
P A5A5C3C D 15

/* dv/tb_opb_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_opb_io_top;
    import opb_io_pkg::*;

    localparam int  NUM_SW      = 12;
    localparam time HALF_PERIOD = 50;
    localparam time SAMPLE_DLY  = 49;
    localparam int  RST_CYCLES  = 10;
    localparam int  RST_TIMEOUT = 40;
    localparam int  MAX_OPS     = 1000;
    // Spare DOUT bits 25..16 have no pin
    localparam logic [27:0] DOUT_PIN_MASK = 28'hC00_FFFF;

    logic                SYSCLK_IN;
    logic                opb_rst;
    opb_addr_t           opb_addr;
    opb_data_t           opb_di;
    opb_data_t           opb_do;
    logic                opb_re;
    logic                opb_we;
    logic                res_clk;
    logic [NUM_SW-1:0]   p_swb;
    logic [31:0]         din_word;

    logic                pd_en_pwr_rot;
    logic                pd_en_pwr_jaw;
    logic                cntl_fpga0;
    logic                cntl_fpga1;
    logic                cntl_fpga2;
    logic                kvbenlp_cntl;
    logic                spenlp_cntl;
    logic                sp485_1_dir;
    logic                sp485_2_dir;
    logic                collision_pwr_en;
    logic                pend_pwr_en;
    logic                acc_ledgrn;
    logic                acc_ledred;
    logic                acc_led_pwr_en;
    logic                acc_rst_lmp_cntl;
    logic                pd_drv_en_fpga_r;
    logic                pd_drv_en_jaw;
    logic                en_12vb;
    logic                lp_mux_en;
    logic [2:0]          lp_mux_s;
    logic [ADSEL_W-1:0]  ad_sel;
    logic [RES_W-1:0]    res_pwm;
    logic [27:0]         dout_pins;

    integer              seed;
    integer              fd;
    integer              code;
    integer              ops;
    integer              cycles;
    logic [7:0]          op;
    logic [31:0]         arg0;
    logic [31:0]         arg1;
    logic [31:0]         arg2;
    logic [8*256-1:0]    line_buf;
    logic                done;

    // Pin positions of the DOUT word with spare bits at zero
    assign dout_pins = {pd_en_pwr_rot, pd_en_pwr_jaw, 10'b0,
                        cntl_fpga0, cntl_fpga1, cntl_fpga2, kvbenlp_cntl, spenlp_cntl,
                        sp485_1_dir, sp485_2_dir, collision_pwr_en, pend_pwr_en,
                        acc_ledgrn, acc_ledred, acc_led_pwr_en, acc_rst_lmp_cntl,
                        pd_drv_en_fpga_r, pd_drv_en_jaw, en_12vb};

    opb_io_top #(
        .num_switches (NUM_SW)
    ) dut (
        .SYSCLK_IN         (SYSCLK_IN),
        .opb_rst           (opb_rst),
        .opb_addr          (opb_addr),
        .opb_di            (opb_di),
        .opb_re            (opb_re),
        .opb_we            (opb_we),
        .opb_do            (opb_do),
        .res_clk           (res_clk),
        .p_swb             (p_swb),
        .hw_rev            (din_word[27:25]),
        .cpld_version      (din_word[15:8]),
        .acc_tg_coll       (din_word[0]),
        .acc_hw_resetb     (din_word[1]),
        .acc_hw_statusb    (din_word[2]),
        .pend_pwr_okb      (din_word[3]),
        .pd_shunt_sense    (din_word[4]),
        .p_ovlb            (din_word[5]),
        .pd_uvflt          (din_word[6]),
        .pend_mot_en_cpldb (din_word[16]),
        .pend_active       (din_word[17]),
        .coll_detectb      (din_word[18]),
        .coll_detect       (din_word[19]),
        .spenlp_state      (din_word[20]),
        .kvbenlp_state     (din_word[21]),
        .cntl_fpga5        (din_word[22]),
        .cntl_fpga4        (din_word[23]),
        .cntl_fpga3        (din_word[24]),
        .p28v_pgood_jawb   (din_word[29]),
        .p28v_pgood_rotb   (din_word[30]),
        .p24v_pgoodb       (din_word[31]),
        .pd_en_pwr_rot     (pd_en_pwr_rot),
        .pd_en_pwr_jaw     (pd_en_pwr_jaw),
        .cntl_fpga0        (cntl_fpga0),
        .cntl_fpga1        (cntl_fpga1),
        .cntl_fpga2        (cntl_fpga2),
        .kvbenlp_cntl      (kvbenlp_cntl),
        .spenlp_cntl       (spenlp_cntl),
        .sp485_1_dir       (sp485_1_dir),
        .sp485_2_dir       (sp485_2_dir),
        .collision_pwr_en  (collision_pwr_en),
        .pend_pwr_en       (pend_pwr_en),
        .acc_ledgrn        (acc_ledgrn),
        .acc_ledred        (acc_ledred),
        .acc_led_pwr_en    (acc_led_pwr_en),
        .acc_rst_lmp_cntl  (acc_rst_lmp_cntl),
        .pd_drv_en_fpga_r  (pd_drv_en_fpga_r),
        .pd_drv_en_jaw     (pd_drv_en_jaw),
        .en_12vb           (en_12vb),
        .lp_mux_en         (lp_mux_en),
        .lp_mux_s          (lp_mux_s),
        .ad_sel            (ad_sel),
        .res_pwm           (res_pwm)
    );

    always #(HALF_PERIOD) SYSCLK_IN = ~SYSCLK_IN;

    initial begin
        opb_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge SYSCLK_IN);
        @(negedge SYSCLK_IN);
        opb_rst = 1'b0;
    end

    //////////////////////////////
    // Checks and bus tasks
    task automatic stop_run(input string why);
        $display("ERROR: %s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic require_fields(input integer got, input integer want);
        if (got != want)
            stop_run("a line in the golden file has too few values");
    endtask

    // Strobes are single cycle, so every step starts idle
    task automatic next_falling_edge();
        @(negedge SYSCLK_IN);
        opb_we = 1'b0;
        opb_re = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        next_falling_edge();
        opb_addr = addr[OPB_ADDR_W-1:0];
        opb_di   = data;
        opb_we   = 1'b1;
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
        next_falling_edge();
        opb_addr = addr[OPB_ADDR_W-1:0];
        opb_re   = 1'b1;
        #(SAMPLE_DLY);
        check_value(opb_do, expected, $sformatf("read of address %h", addr));
    endtask

    task automatic set_inputs(input logic [31:0] word, input logic [31:0] sw);
        next_falling_edge();
        din_word = word;
        p_swb    = sw[NUM_SW-1:0];
    endtask

    task automatic check_pins(input logic [31:0] dout_exp, input logic [31:0] lpmux_exp,
                              input logic [31:0] adsel_exp);
        next_falling_edge();
        #(SAMPLE_DLY);
        check_value(dout_pins, dout_exp[27:0] & DOUT_PIN_MASK, "digital output pins");
        check_value({lp_mux_en, lp_mux_s}, lpmux_exp[3:0], "loop mux pins");
        check_value(ad_sel, adsel_exp[ADSEL_W-1:0], "analog select pins");
    endtask

    task automatic check_resolver(input logic [31:0] clk_val, input logic [31:0] expected);
        next_falling_edge();
        res_clk = clk_val[0];
        #(SAMPLE_DLY);
        check_value(res_pwm, expected[RES_W-1:0], "resolver PWM pins");
    endtask

    // Random bus traffic with both strobes low
    task automatic idle_random(input integer count, input logic [31:0] expected);
        integer      i;
        logic [31:0] rnd;
        for (i = 0; i < count; i++) begin
            next_falling_edge();
            rnd      = $random(seed);
            opb_addr = rnd[OPB_ADDR_W-1:0];
            opb_di   = $random(seed);
            #(SAMPLE_DLY);
            check_value(opb_do, expected, "opb_do with opb_re low");
        end
    endtask

    //////////////////////////////
    // Golden file replay
    initial begin
        SYSCLK_IN = 1'b0;
        opb_addr  = '0;
        opb_di    = '0;
        opb_re    = 1'b0;
        opb_we    = 1'b0;
        res_clk   = 1'b0;
        p_swb     = '0;
        din_word  = '0;
        seed      = 14833;
        ops       = 0;
        done      = 1'b0;

        fd = $fopen("dv/opb_io_golden.txt", "r");
        if (fd == 0)
            stop_run("cannot open the golden file dv/opb_io_golden.txt");

        cycles = 0;
        while (opb_rst !== 1'b0 && cycles < RST_TIMEOUT) begin
            @(negedge SYSCLK_IN);
            cycles++;
        end
        if (opb_rst !== 1'b0)
            stop_run("reset was never released");

        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                ops++;
                if (ops > MAX_OPS)
                    stop_run("the golden file has more lines than expected");
                case (op)
                    "#": code = $fgets(line_buf, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", arg0, arg1);
                        require_fields(code, 2);
                        bus_write(arg0, arg1);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", arg0, arg1);
                        require_fields(code, 2);
                        bus_read(arg0, arg1);
                    end
                    "I": begin
                        code = $fscanf(fd, "%h %h", arg0, arg1);
                        require_fields(code, 2);
                        set_inputs(arg0, arg1);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h %h", arg0, arg1, arg2);
                        require_fields(code, 3);
                        check_pins(arg0, arg1, arg2);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %h", arg0, arg1);
                        require_fields(code, 2);
                        check_resolver(arg0, arg1);
                    end
                    "Z": begin
                        code = $fscanf(fd, "%h %h", arg0, arg1);
                        require_fields(code, 2);
                        idle_random(arg0, arg1);
                    end
                    default: stop_run("unknown opcode in the golden file");
                endcase
            end
        end
        $fclose(fd);
        if (ops == 0) begin
            stop_run("the golden file holds no operations");
        end else begin
            next_falling_edge();
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
rtl/opb_io_pkg.sv
rtl/opb_reg_if.sv
rtl/opb_addr_decode.sv
rtl/output_reg_bank.sv
rtl/input_sampler.sv
rtl/read_data_mux.sv
rtl/opb_io_top.sv
dv/tb_opb_io_top.sv

/* rtl/input_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module input_sampler #(
    parameter int num_switches = opb_io_pkg::NUM_SWITCHES
) (
    input wire logic                    SYSCLK_IN,
    input wire logic                    opb_rst,
    input wire opb_io_pkg::din_t        din_pins,
    input wire logic [num_switches-1:0] sw_pins,
    opb_reg_if.unit                     bus,
    output opb_io_pkg::opb_data_t       rdata
);
    import opb_io_pkg::*;

    // Bits 7 and 28 carry no pin
    localparam opb_data_t RSVD_MASK = 32'h1000_0080;

    din_t                    din_q;
    logic [num_switches-1:0] sw_q;

    // Free running sample without a write path
    always_ff @(posedge SYSCLK_IN or posedge opb_rst) begin
        if (opb_rst) begin
            din_q <= '0;
            sw_q  <= '0;
        end else begin
            din_q <= din_t'(din_pins & ~RSVD_MASK);
            sw_q  <= sw_pins;
        end
    end

    always_comb begin
        rdata = '0;
        if (bus.re) begin
            case (bus.sel)
                SEL_DIN: rdata = din_q;
                SEL_PSW: rdata = OPB_DATA_W'(sw_q);
                default: rdata = '0;
            endcase
        end
    end

    // Undriven pins would reach the bus as X
    assert property (@(posedge SYSCLK_IN) disable iff (opb_rst)
        !$isunknown({din_pins, sw_pins}))
        else $error("DIN or switch pins unknown");

endmodule

`default_nettype wire

/* rtl/opb_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module opb_addr_decode (
    input wire opb_io_pkg::opb_addr_t opb_addr,
    input wire opb_io_pkg::opb_data_t opb_di,
    input wire logic                  opb_re,
    input wire logic                  opb_we,
    opb_reg_if.decoder                bus
);
    import opb_io_pkg::*;

    reg_sel_e sel;

    // Word aligned, byte lanes ignored
    always_comb begin
        sel = SEL_NONE;
        case ({opb_addr[OPB_ADDR_W-1:2], 2'b00})
            ADDR_SP1:     sel = SEL_SP1;
            ADDR_SP2:     sel = SEL_SP2;
            ADDR_DOUT:    sel = SEL_DOUT;
            ADDR_LPMUX:   sel = SEL_LPMUX;
            ADDR_ADSEL:   sel = SEL_ADSEL;
            ADDR_RES_OUT: sel = SEL_RES_OUT;
            ADDR_DIN:     sel = SEL_DIN;
            ADDR_PSW:     sel = SEL_PSW;
            default:      sel = SEL_NONE;
        endcase

        // Bus master never reads and writes in the same cycle
        assert final ($isunknown({opb_re, opb_we}) || !(opb_re && opb_we))
            else $error("opb_re and opb_we high together");
    end

    assign bus.sel   = sel;
    assign bus.wdata = opb_di;
    assign bus.we    = opb_we;
    assign bus.re    = opb_re;

endmodule

`default_nettype wire

/* rtl/opb_io_pkg.sv */
`default_nettype none

package opb_io_pkg;

    parameter int OPB_DATA_W   = 32;
    parameter int OPB_ADDR_W   = 24;
    parameter int RES_W        = 20;
    parameter int ADSEL_W      = 7;
    parameter int NUM_SWITCHES = 12;

    typedef logic [OPB_DATA_W-1:0] opb_data_t;
    typedef logic [OPB_ADDR_W-1:0] opb_addr_t;

    typedef enum logic [3:0] {
        SEL_SP1,
        SEL_SP2,
        SEL_DOUT,
        SEL_LPMUX,
        SEL_ADSEL,
        SEL_RES_OUT,
        SEL_DIN,
        SEL_PSW,
        SEL_NONE
    } reg_sel_e;

    //////////////////////////////
    // Register map, byte offsets
    parameter opb_addr_t ADDR_SP1     = 24'h000;
    parameter opb_addr_t ADDR_SP2     = 24'h004;
    parameter opb_addr_t ADDR_DOUT    = 24'h008;
    parameter opb_addr_t ADDR_LPMUX   = 24'h00C;
    parameter opb_addr_t ADDR_ADSEL   = 24'h010;
    parameter opb_addr_t ADDR_RES_OUT = 24'h014;
    parameter opb_addr_t ADDR_DIN     = 24'h018;
    parameter opb_addr_t ADDR_PSW     = 24'h01C;

    //////////////////////////////
    // Digital output word
    typedef struct packed {
        logic       pwr_rot;
        logic       pwr_jaw;
        logic [9:0] spare;
        // Loop enables 0..2 on the CPLD side
        logic       cntl_fpga0;
        logic       cntl_fpga1;
        logic       cntl_fpga2;
        logic       kvbenlp_cntl;
        logic       spenlp_cntl;
        logic       sp485_1_dir;
        logic       sp485_2_dir;
        logic       collision_pwr_en;
        logic       pend_pwr_en;
        logic       acc_ledgrn;
        logic       acc_ledred;
        logic       acc_led_pwr_en;
        logic       acc_rst_lmp_cntl;
        logic       pd_drv_en_fpga_r;
        logic       pd_drv_en_jaw;
        logic       en_12vb;
    } dout_t;

    // Digital input word, bit 31 first
    typedef struct packed {
        logic       p24v_pgoodb;
        logic       p28v_pgood_rotb;
        logic       p28v_pgood_jawb;
        logic       rsvd_28;
        logic [2:0] hw_rev;
        logic       cntl_fpga3;
        logic       cntl_fpga4;
        logic       cntl_fpga5;
        logic       kvbenlp_state;
        logic       spenlp_state;
        logic       coll_detect;
        logic       coll_detectb;
        logic       pend_active;
        logic       pend_mot_en_cpldb;
        logic [7:0] cpld_version;
        logic       rsvd_7;
        logic       pd_uvflt;
        logic       p_ovlb;
        logic       pd_shunt_sense;
        logic       pend_pwr_okb;
        logic       acc_hw_statusb;
        logic       acc_hw_resetb;
        logic       acc_tg_coll;
    } din_t;

    typedef struct packed {
        logic       en;
        logic [2:0] sel;
    } lpmux_t;

    parameter opb_data_t SP1_RESET  = 32'hF5F5_F5F5;
    parameter opb_data_t SP2_RESET  = 32'hACAC_ACAC;
    parameter dout_t     DOUT_RESET = 28'h003_0001;

endpackage

`default_nettype wire

/* rtl/opb_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module opb_io_top #(
    parameter int num_switches = opb_io_pkg::NUM_SWITCHES
) (
    input wire logic                            SYSCLK_IN,
    input wire logic                            opb_rst,

    input wire opb_io_pkg::opb_addr_t           opb_addr,
    input wire opb_io_pkg::opb_data_t           opb_di,
    input wire logic                            opb_re,
    input wire logic                            opb_we,
    output opb_io_pkg::opb_data_t               opb_do,

    input wire logic                            res_clk,

    input wire logic [num_switches-1:0]         p_swb,
    input wire logic [2:0]                      hw_rev,
    input wire logic [7:0]                      cpld_version,

    // Status pins
    input wire logic                            acc_tg_coll,
    input wire logic                            acc_hw_resetb,
    input wire logic                            acc_hw_statusb,
    input wire logic                            p_ovlb,
    input wire logic                            pd_uvflt,
    input wire logic                            pend_mot_en_cpldb,
    input wire logic                            pend_active,
    input wire logic                            pend_pwr_okb,
    input wire logic                            coll_detectb,
    input wire logic                            coll_detect,
    input wire logic                            spenlp_state,
    input wire logic                            kvbenlp_state,
    input wire logic                            cntl_fpga5,
    input wire logic                            cntl_fpga4,
    input wire logic                            cntl_fpga3,
    input wire logic                            p28v_pgood_jawb,
    input wire logic                            p28v_pgood_rotb,
    input wire logic                            p24v_pgoodb,
    input wire logic                            pd_shunt_sense,

    // Control pins
    output logic                                pd_en_pwr_rot,
    output logic                                pd_en_pwr_jaw,
    output logic                                cntl_fpga0,
    output logic                                cntl_fpga1,
    output logic                                cntl_fpga2,
    output logic                                kvbenlp_cntl,
    output logic                                spenlp_cntl,
    output logic                                sp485_1_dir,
    output logic                                sp485_2_dir,
    output logic                                collision_pwr_en,
    output logic                                pend_pwr_en,
    output logic                                acc_ledgrn,
    output logic                                acc_ledred,
    output logic                                acc_led_pwr_en,
    output logic                                acc_rst_lmp_cntl,
    output logic                                pd_drv_en_fpga_r,
    output logic                                pd_drv_en_jaw,
    output logic                                en_12vb,

    output logic                                lp_mux_en,
    output logic [2:0]                          lp_mux_s,
    output logic [opb_io_pkg::ADSEL_W-1:0]      ad_sel,
    output logic [opb_io_pkg::RES_W-1:0]        res_pwm
);
    import opb_io_pkg::*;

    din_t      din_pins;
    dout_t     dout;
    lpmux_t    lp_mux;
    opb_data_t out_rdata;
    opb_data_t in_rdata;

    opb_reg_if bus ();

    //////////////////////////////
    // Pin packing
    assign din_pins = '{
        p24v_pgoodb:       p24v_pgoodb,
        p28v_pgood_rotb:   p28v_pgood_rotb,
        p28v_pgood_jawb:   p28v_pgood_jawb,
        rsvd_28:           1'b0,
        hw_rev:            hw_rev,
        cntl_fpga3:        cntl_fpga3,
        cntl_fpga4:        cntl_fpga4,
        cntl_fpga5:        cntl_fpga5,
        kvbenlp_state:     kvbenlp_state,
        spenlp_state:      spenlp_state,
        coll_detect:       coll_detect,
        coll_detectb:      coll_detectb,
        pend_active:       pend_active,
        pend_mot_en_cpldb: pend_mot_en_cpldb,
        cpld_version:      cpld_version,
        rsvd_7:            1'b0,
        pd_uvflt:          pd_uvflt,
        p_ovlb:            p_ovlb,
        pd_shunt_sense:    pd_shunt_sense,
        pend_pwr_okb:      pend_pwr_okb,
        acc_hw_statusb:    acc_hw_statusb,
        acc_hw_resetb:     acc_hw_resetb,
        acc_tg_coll:       acc_tg_coll
    };

    // Spare DOUT bits have no pin
    assign pd_en_pwr_rot    = dout.pwr_rot;
    assign pd_en_pwr_jaw    = dout.pwr_jaw;
    assign cntl_fpga0       = dout.cntl_fpga0;
    assign cntl_fpga1       = dout.cntl_fpga1;
    assign cntl_fpga2       = dout.cntl_fpga2;
    assign kvbenlp_cntl     = dout.kvbenlp_cntl;
    assign spenlp_cntl      = dout.spenlp_cntl;
    assign sp485_1_dir      = dout.sp485_1_dir;
    assign sp485_2_dir      = dout.sp485_2_dir;
    assign collision_pwr_en = dout.collision_pwr_en;
    assign pend_pwr_en      = dout.pend_pwr_en;
    assign acc_ledgrn       = dout.acc_ledgrn;
    assign acc_ledred       = dout.acc_ledred;
    assign acc_led_pwr_en   = dout.acc_led_pwr_en;
    assign acc_rst_lmp_cntl = dout.acc_rst_lmp_cntl;
    assign pd_drv_en_fpga_r = dout.pd_drv_en_fpga_r;
    assign pd_drv_en_jaw    = dout.pd_drv_en_jaw;
    assign en_12vb          = dout.en_12vb;

    assign lp_mux_en = lp_mux.en;
    assign lp_mux_s  = lp_mux.sel;

    //////////////////////////////
    // Units
    opb_addr_decode u_decode (
        .opb_addr (opb_addr),
        .opb_di   (opb_di),
        .opb_re   (opb_re),
        .opb_we   (opb_we),
        .bus      (bus.decoder)
    );

    output_reg_bank u_out_bank (
        .SYSCLK_IN (SYSCLK_IN),
        .opb_rst   (opb_rst),
        .res_clk   (res_clk),
        .bus       (bus.unit),
        .dout      (dout),
        .lp_mux    (lp_mux),
        .ad_sel    (ad_sel),
        .res_pwm   (res_pwm),
        .rdata     (out_rdata)
    );

    input_sampler #(
        .num_switches (num_switches)
    ) u_in_sampler (
        .SYSCLK_IN (SYSCLK_IN),
        .opb_rst   (opb_rst),
        .din_pins  (din_pins),
        .sw_pins   (p_swb),
        .bus       (bus.unit),
        .rdata     (in_rdata)
    );

    read_data_mux u_rd_mux (
        .bus       (bus.reader),
        .opb_re    (opb_re),
        .out_rdata (out_rdata),
        .in_rdata  (in_rdata),
        .opb_do    (opb_do)
    );

endmodule

`default_nettype wire

/* rtl/opb_reg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface opb_reg_if;
    import opb_io_pkg::*;

    reg_sel_e  sel;
    opb_data_t wdata;
    logic      we;
    logic      re;

    modport decoder (
        output sel,
        output wdata,
        output we,
        output re
    );

    modport unit (
        input sel,
        input wdata,
        input we,
        input re
    );

    // Read path only needs the select
    modport reader (
        input sel
    );

endinterface

`default_nettype wire

/* rtl/output_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module output_reg_bank (
    input wire logic                        SYSCLK_IN,
    input wire logic                        opb_rst,
    input wire logic                        res_clk,
    opb_reg_if.unit                         bus,
    output opb_io_pkg::dout_t               dout,
    output opb_io_pkg::lpmux_t              lp_mux,
    output logic [opb_io_pkg::ADSEL_W-1:0]  ad_sel,
    output logic [opb_io_pkg::RES_W-1:0]    res_pwm,
    output opb_io_pkg::opb_data_t           rdata
);
    import opb_io_pkg::*;

    opb_data_t          sp1_q;
    opb_data_t          sp2_q;
    dout_t              dout_q;
    lpmux_t             lpmux_q;
    logic [ADSEL_W-1:0] adsel_q;
    logic [RES_W-1:0]   res_q;

    //////////////////////////////
    // Write side
    always_ff @(posedge SYSCLK_IN or posedge opb_rst) begin
        if (opb_rst) begin
            sp1_q   <= SP1_RESET;
            sp2_q   <= SP2_RESET;
            dout_q  <= DOUT_RESET;
            lpmux_q <= '0;
            adsel_q <= '0;
            res_q   <= '0;
        end else if (bus.we) begin
            case (bus.sel)
                SEL_SP1:     sp1_q   <= bus.wdata;
                SEL_SP2:     sp2_q   <= bus.wdata;
                SEL_DOUT:    dout_q  <= dout_t'(bus.wdata[$bits(dout_t)-1:0]);
                SEL_LPMUX:   lpmux_q <= lpmux_t'(bus.wdata[$bits(lpmux_t)-1:0]);
                SEL_ADSEL:   adsel_q <= bus.wdata[ADSEL_W-1:0];
                SEL_RES_OUT: res_q   <= bus.wdata[RES_W-1:0];
                // Input registers are read only
                default: ;
            endcase
        end
    end

    assign dout   = dout_q;
    assign lp_mux = lpmux_q;
    assign ad_sel = adsel_q;

    //////////////////////////////
    // Resolver PWM
    // Odd channels drive the inverted leg
    for (genvar i = 0; i < RES_W; i++) begin : g_res
        if (i % 2 == 0) begin : g_even
            assign res_pwm[i] = res_q[i] & res_clk;
        end else begin : g_odd
            assign res_pwm[i] = ~(res_q[i] & res_clk);
        end
    end

    //////////////////////////////
    // Read side
    always_comb begin
        rdata = '0;
        if (bus.re) begin
            case (bus.sel)
                SEL_SP1:     rdata = sp1_q;
                SEL_SP2:     rdata = sp2_q;
                SEL_DOUT:    rdata = OPB_DATA_W'(dout_q);
                SEL_LPMUX:   rdata = OPB_DATA_W'(lpmux_q);
                SEL_ADSEL:   rdata = OPB_DATA_W'(adsel_q);
                SEL_RES_OUT: rdata = OPB_DATA_W'(res_q);
                default:     rdata = '0;
            endcase
        end
    end

    // A write must carry known data
    assert property (@(posedge SYSCLK_IN) disable iff (opb_rst)
        bus.we |-> !$isunknown(bus.wdata))
        else $error("write data unknown");

endmodule

`default_nettype wire

/* rtl/read_data_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module read_data_mux (
    opb_reg_if.reader                 bus,
    input wire logic                  opb_re,
    input wire opb_io_pkg::opb_data_t out_rdata,
    input wire opb_io_pkg::opb_data_t in_rdata,
    output opb_io_pkg::opb_data_t     opb_do
);
    import opb_io_pkg::*;

    // Idle bus reads back zero
    always_comb begin
        opb_do = '0;
        if (opb_re) begin
            case (bus.sel)
                SEL_DIN,
                SEL_PSW: opb_do = in_rdata;
                // Unmapped selects already return zero from the bank
                default: opb_do = out_rdata;
            endcase
        end
    end

endmodule

`default_nettype wire
